//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/icache_array_if.sv
`timescale 1ns/1ps

interface icache_array_if;
  import icache_pkg::*;

  // lookup side, straight from the cpu address
  icache_index_t  index;
  icache_tag_t    lookup_tag;
  icache_offset_t offset;

  // refill write, shared by both arrays
  logic           fill_en;
  icache_tag_t    fill_tag;
  icache_index_t  fill_index;
  icache_line_t   fill_line;

  // array responses
  logic           hit;
  icache_line_t   line_rdata;

  modport ctrl (
    output index, lookup_tag, offset,
    output fill_en, fill_tag, fill_index, fill_line,
    input  hit, line_rdata
  );

  modport tag (
    input  index, lookup_tag, fill_en, fill_tag, fill_index,
    output hit
  );

  modport data (
    input  index, fill_en, fill_index, fill_line,
    output line_rdata
  );

endinterface

//--- common/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry, direct mapped, 512 bytes
`define ICACHE_LINES      32
`define ICACHE_LINE_BYTES 16

// address split: tag | index | offset
`define ICACHE_TAG_W      23
`define ICACHE_INDEX_W    5
`define ICACHE_OFFSET_W   4

// cpu and memory data word
`define ICACHE_XLEN       64

`endif

//--- common/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

  // address fields
  typedef logic [31:0]                   icache_addr_t;
  typedef logic [`ICACHE_TAG_W-1:0]      icache_tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]    icache_index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0]   icache_offset_t;

  // storage and bus words
  typedef logic [`ICACHE_LINE_BYTES*8-1:0] icache_line_t;
  typedef logic [`ICACHE_XLEN-1:0]         icache_xlen_t;

  // controller states, FILL is the array write cycle
  typedef enum logic [2:0] {
    ST_RST,
    ST_IDLE,
    ST_MISS_LO,
    ST_MISS_HI,
    ST_FILL
  } icache_state_e;

endpackage

//--- dv/icache_checker.sv
`timescale 1ns/1ps

module icache_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::icache_xlen_t fetch_rdata_i,
  input  logic                     fetch_rdata_valid_i,
  input  icache_pkg::icache_addr_t mem_raddr_i,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_rready_i
);
  import icache_pkg::*;

  // fetches driven but not yet answered, oldest first
  string        name_q[$];
  icache_addr_t addr_q[$];
  logic [31:0]  instr_q[$];
  bit           refill_q[$];

  int beats;
  int checked;
  int errors;

  task automatic expect_fetch(input string name, input icache_addr_t addr,
                              input logic [31:0] instr, input bit refill);
    name_q.push_back(name);
    addr_q.push_back(addr);
    instr_q.push_back(instr);
    refill_q.push_back(refill);
  endtask

  always @(posedge clk) begin
    icache_addr_t beat_addr;
    int           exp_beats;
    if (rst) begin
      beats = 0;
    end else if (addr_q.size() == 0) begin
      if (fetch_rdata_valid_i || mem_rvalid_i) begin
        errors++;
        $display("error: valid output high at %0t with no fetch pending", $time);
      end
    end else begin
      // beats walk the line from its base, 8 bytes each
      if (mem_rvalid_i && mem_rready_i) begin
        beat_addr = {addr_q[0][31:4], 4'h0} + icache_addr_t'(beats * 8);
        if (mem_raddr_i !== beat_addr) begin
          errors++;
          $display("mismatch %s beat %0d address: expected %h actual %h",
                   name_q[0], beats, beat_addr, mem_raddr_i);
        end
        beats++;
      end
      if (fetch_rdata_valid_i) begin
        exp_beats = refill_q[0] ? 2 : 0;
        if (fetch_rdata_i[31:0] !== instr_q[0]) begin
          errors++;
          $display("mismatch %s instruction: expected %h actual %h",
                   name_q[0], instr_q[0], fetch_rdata_i[31:0]);
        end
        if (fetch_rdata_i[63:32] !== 32'h0) begin
          errors++;
          $display("mismatch %s upper word: expected %h actual %h",
                   name_q[0], 32'h0, fetch_rdata_i[63:32]);
        end
        if (beats != exp_beats) begin
          errors++;
          $display("mismatch %s memory beats: expected %0d actual %0d",
                   name_q[0], exp_beats, beats);
        end
        checked++;
        beats = 0;
        void'(name_q.pop_front());
        void'(addr_q.pop_front());
        void'(instr_q.pop_front());
        void'(refill_q.pop_front());
      end
    end
    if (!rst && !fetch_rdata_valid_i && fetch_rdata_i !== '0) begin
      errors++;
      $display("error: instruction output not zero at %0t while its valid is low", $time);
    end
  end

endmodule

//--- dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam string       TRACE_PATH     = "dv/icache_trace.txt";
  localparam int          FETCH_CYCLES   = 20;
  localparam int          TIMEOUT_MARGIN = 200;
  localparam int          RESET_CYCLES   = 16;
  localparam int          PASSES         = 2;
  localparam logic [31:0] SEED           = 32'hd3562ae2;
  localparam logic [31:0] MEM_KEY        = 32'h13572468;

  logic         clk;
  logic         rst;
  icache_addr_t fetch_addr;
  logic         fetch_valid;
  icache_xlen_t fetch_rdata;
  logic         fetch_rdata_valid;
  icache_addr_t mem_raddr;
  logic         mem_rvalid;
  logic         mem_rready;
  icache_xlen_t mem_rdata;

  // one entry per trace line
  string        names[$];
  icache_addr_t addrs[$];
  logic [31:0]  instrs[$];
  bit           refills[$];

  integer seed;
  int     cycles;
  int     cycle_limit;

  icache_top icache_top_i (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_raddr_o         (mem_raddr),
    .mem_rvalid_o        (mem_rvalid),
    .mem_rready_i        (mem_rready),
    .mem_rdata_i         (mem_rdata)
  );

  icache_checker chk (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_rdata_valid_i (fetch_rdata_valid),
    .mem_raddr_i         (mem_raddr),
    .mem_rvalid_i        (mem_rvalid),
    .mem_rready_i        (mem_rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // each memory word is its own address xor a key
  // lower address in the low half of the beat
  function automatic icache_xlen_t mem_beat(input icache_addr_t addr);
    icache_addr_t base;
    base = {addr[31:3], 3'b000};
    return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
  endfunction

  task automatic load_trace();
    int           fd;
    int           got;
    string        line;
    string        name;
    icache_addr_t addr;
    logic [31:0]  instr;
    int           refill;
    fd = $fopen(TRACE_PATH, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        // skip comments and blank lines
        if (got > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %h %h %d", name, addr, instr, refill) == 4) begin
            names.push_back(name);
            addrs.push_back(addr);
            instrs.push_back(instr);
            refills.push_back(refill != 0);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // hold the fetch until the cache answers it
  task automatic run_fetch(input int i);
    chk.expect_fetch(names[i], addrs[i], instrs[i], refills[i]);
    fetch_addr  = addrs[i];
    fetch_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!fetch_rdata_valid);
  endtask

  // memory answers each beat after 0 to 3 idle cycles
  initial begin
    int delay;
    forever begin
      @(negedge clk);
      mem_rready = 1'b0;
      if (!rst && mem_rvalid) begin
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk);
        mem_rdata  = mem_beat(mem_raddr);
        mem_rready = 1'b1;
      end
    end
  end

  initial begin
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (cycles < cycle_limit);
    $display("error: timeout after %0d cycles, %0d of %0d fetches checked, %0d errors",
             cycles, chk.checked, PASSES * names.size(), chk.errors);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed        = SEED;
    rst         = 1'b1;
    fetch_addr  = '0;
    fetch_valid = 1'b0;
    mem_rready  = 1'b0;
    mem_rdata   = '0;
    load_trace();
    cycle_limit = PASSES * names.size() * FETCH_CYCLES + TIMEOUT_MARGIN;
    if (names.size() == 0) begin
      $display("error: no fetches read from %s", TRACE_PATH);
      $display("Some tests failed");
      $finish;
    end else begin
      // the second pass follows a reset of a full cache, so every line misses again
      repeat (PASSES) begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // quiet cycles with both valid outputs low
        repeat (3) @(negedge clk);
        foreach (names[i]) begin
          run_fetch(i);
        end
        fetch_valid = 1'b0;
        repeat (4) @(negedge clk);
      end
      $display("fetches %0d, checked %0d, errors %0d",
               PASSES * names.size(), chk.checked, chk.errors);
      if (chk.errors == 0 && chk.checked == PASSES * names.size()) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

//--- dv/icache_trace.txt
# name  address  expected_instruction  refill (1 when the fetch goes to memory)
# address and instruction in hex; instruction = word address xor 13572468
cold_miss 00001000 13573468 1
same_line 00001004 1357346c 0
same_line 00001008 13573460 0
same_line 0000100c 13573464 0
conflict 00002010 13570478 1
conflict 0000301c 13571474 1
conflict 00002014 1357047c 1
conflict 00003018 13571470 1
fill 00004020 13576448 1
fill 00004030 13576458 1
fill 00004040 13576428 1
fill 00004050 13576438 1
fill 00004060 13576408 1
fill 00004070 13576418 1
fill 00004080 135764e8 1
fill 00004090 135764f8 1
fill 000040a0 135764c8 1
fill 000040b0 135764d8 1
fill 000040c0 135764a8 1
fill 000040d0 135764b8 1
fill 000040e0 13576488 1
fill 000040f0 13576498 1
fill 00004100 13576568 1
fill 00004110 13576578 1
fill 00004120 13576548 1
fill 00004130 13576558 1
fill 00004140 13576528 1
fill 00004150 13576538 1
fill 00004160 13576508 1
fill 00004170 13576518 1
fill 00004180 135765e8 1
fill 00004190 135765f8 1
fill 000041a0 135765c8 1
fill 000041b0 135765d8 1
fill 000041c0 135765a8 1
fill 000041d0 135765b8 1
fill 000041e0 13576588 1
fill 000041f0 13576598 1
revisit 00001000 13573468 0
revisit 00003014 1357147c 0
revisit 00004028 13576440 0
revisit 0000403c 13576454 0
revisit 00004040 13576428 0
revisit 00004054 1357643c 0
revisit 00004068 13576400 0
revisit 0000407c 13576414 0
revisit 00004080 135764e8 0
revisit 00004094 135764fc 0
revisit 000040a8 135764c0 0
revisit 000040bc 135764d4 0
revisit 000040c0 135764a8 0
revisit 000040d4 135764bc 0
revisit 000040e8 13576480 0
revisit 000040fc 13576494 0
revisit 00004100 13576568 0
revisit 00004114 1357657c 0
revisit 00004128 13576540 0
revisit 0000413c 13576554 0
revisit 00004140 13576528 0
revisit 00004154 1357653c 0
revisit 00004168 13576500 0
revisit 0000417c 13576514 0
revisit 00004180 135765e8 0
revisit 00004194 135765fc 0
revisit 000041a8 135765c0 0
revisit 000041bc 135765d4 0
revisit 000041c0 135765a8 0
revisit 000041d4 135765bc 0
revisit 000041e8 13576580 0
revisit 000041fc 13576594 0

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  // cpu fetch port
  input  icache_pkg::icache_addr_t fetch_addr_i,
  input  logic                     fetch_valid_i,
  output icache_pkg::icache_xlen_t fetch_rdata_o,
  output logic                     fetch_rdata_valid_o,
  // memory read port
  output icache_pkg::icache_addr_t mem_raddr_o,
  output logic                     mem_rvalid_o,
  input  logic                     mem_rready_i,
  input  icache_pkg::icache_xlen_t mem_rdata_i,
  // tag and data arrays
  icache_array_if.ctrl             ca
);
  import icache_pkg::*;

  localparam int OFFSET_W = $bits(icache_offset_t);
  localparam int INDEX_W  = $bits(icache_index_t);

  // second beat starts halfway through the line
  localparam icache_offset_t HI_BEAT_OFFSET = icache_offset_t'(`ICACHE_LINE_BYTES / 2);

  icache_state_e  state_q;

  // request captured in IDLE
  icache_tag_t    tag_q;
  icache_index_t  index_q;
  icache_offset_t offset_q;

  logic           rdata_ok_q;
  icache_addr_t   mem_raddr_q;
  logic           mem_rvalid_q;

  // line being assembled from memory
  icache_xlen_t   beat_lo_q;
  icache_xlen_t   beat_hi_q;

  logic [OFFSET_W-3:0] word_sel;
  logic [31:0]         word;

  // lookup fields come straight from the cpu address
  assign ca.offset     = icache_offset_t'(fetch_addr_i);
  assign ca.index      = icache_index_t'(fetch_addr_i >> OFFSET_W);
  assign ca.lookup_tag = icache_tag_t'(fetch_addr_i >> (OFFSET_W + INDEX_W));

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_RST;
      rdata_ok_q   <= 1'b0;
      mem_rvalid_q <= 1'b0;
    end else begin
      rdata_ok_q <= 1'b0;
      case (state_q)
        ST_RST: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (fetch_valid_i) begin
            if (ca.hit) begin
              rdata_ok_q <= 1'b1;
            end else begin
              state_q      <= ST_MISS_LO;
              mem_rvalid_q <= 1'b1;
            end
          end
        end
        ST_MISS_LO: begin
          if (mem_rready_i) begin
            state_q <= ST_MISS_HI;
          end
        end
        ST_MISS_HI: begin
          if (mem_rready_i) begin
            state_q      <= ST_FILL;
            mem_rvalid_q <= 1'b0;
          end
        end
        ST_FILL: begin
          // arrays written this cycle, replay lookup in IDLE
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // request latch, memory address and refill beats
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && fetch_valid_i) begin
      tag_q       <= ca.lookup_tag;
      index_q     <= ca.index;
      offset_q    <= ca.offset;
      mem_raddr_q <= {ca.lookup_tag, ca.index, icache_offset_t'(0)};
    end
    if (state_q == ST_MISS_LO && mem_rready_i) begin
      beat_lo_q   <= mem_rdata_i;
      mem_raddr_q <= {tag_q, index_q, HI_BEAT_OFFSET};
    end
    if (state_q == ST_MISS_HI && mem_rready_i) begin
      beat_hi_q <= mem_rdata_i;
    end
  end

  // refill write, low beat in the low half
  assign ca.fill_en    = (state_q == ST_FILL);
  assign ca.fill_tag   = tag_q;
  assign ca.fill_index = index_q;
  assign ca.fill_line  = {beat_hi_q, beat_lo_q};

  // pick the 32-bit instruction out of the registered line
  assign word_sel = offset_q[OFFSET_W-1:2];
  assign word     = ca.line_rdata[word_sel*32 +: 32];

  assign fetch_rdata_valid_o = rdata_ok_q;
  assign fetch_rdata_o       = rdata_ok_q ? icache_xlen_t'(word) : '0;

  assign mem_raddr_o  = mem_raddr_q;
  assign mem_rvalid_o = mem_rvalid_q;

endmodule

//--- icache/icache_data.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data (
  input  logic         clk,
  icache_array_if.data da
);
  import icache_pkg::*;

  icache_line_t mem_q [`ICACHE_LINES];
  icache_line_t rdata_q;

  // single port, a write takes the place of the read
  always_ff @(posedge clk) begin
    if (da.fill_en) begin
      mem_q[da.fill_index] <= da.fill_line;
    end else begin
      rdata_q <= mem_q[da.index];
    end
  end

  assign da.line_rdata = rdata_q;

endmodule

//--- icache/icache_tag.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tag (
  input  logic        clk,
  input  logic        rst,
  icache_array_if.tag ta
);
  import icache_pkg::*;

  icache_tag_t             tags_q [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;

  // line valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (ta.fill_en) begin
      valid_q[ta.fill_index] <= 1'b1;
    end
  end

  // tag contents guarded by the valid bits
  always_ff @(posedge clk) begin
    if (ta.fill_en) begin
      tags_q[ta.fill_index] <= ta.fill_tag;
    end
  end

  // combinational compare at the lookup index
  assign ta.hit = valid_q[ta.index] && (tags_q[ta.index] == ta.lookup_tag);

endmodule

//--- icache_top.f
+incdir+common
common/icache_pkg.sv
common/icache_array_if.sv
icache/icache_tag.sv
icache/icache_data.sv
icache/icache_ctrl.sv
rtl/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                     clk,
  input  logic                     rst,
  // cpu side
  input  icache_pkg::icache_addr_t fetch_addr_i,
  input  logic                     fetch_valid_i,
  output icache_pkg::icache_xlen_t fetch_rdata_o,
  output logic                     fetch_rdata_valid_o,
  // memory side
  output icache_pkg::icache_addr_t mem_raddr_o,
  output logic                     mem_rvalid_o,
  input  logic                     mem_rready_i,
  input  icache_pkg::icache_xlen_t mem_rdata_i
);

  // controller to arrays
  icache_array_if array_if ();

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .mem_raddr_o         (mem_raddr_o),
    .mem_rvalid_o        (mem_rvalid_o),
    .mem_rready_i        (mem_rready_i),
    .mem_rdata_i         (mem_rdata_i),
    .ca                  (array_if.ctrl)
  );

  icache_tag u_tag (
    .clk (clk),
    .rst (rst),
    .ta  (array_if.tag)
  );

  icache_data u_data (
    .clk (clk),
    .da  (array_if.data)
  );

endmodule
